/* sim.f */
src/vfu_pkg.sv
src/vfu_lane_alu.sv
src/vfu_decode.sv
src/vfu_execute.sv
src/vfu_result.sv
src/vfu_top.sv
sim/tb_clock.sv
sim/tb_vfu.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log

verilator --binary --timing --assert -f sim.f --top-module tb_vfu -Mdir obj_dir -o tb_vfu \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_vfu > sim.log 2>&1
cat sim.log

grep -qx "=== PASS ===" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/tb_vfu.sv */
////////////////////
// Testbench for the integer vector functional unit
// Sources come from v0 to v15 and results go to v16 to v31, so requests
// in flight together never have a hazard between them
////////////////////

module tb_vfu;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int NR_ADDR      = vfu_pkg::NR_VREG * vfu_pkg::NR_WORDS_PER_VREG;

  // Words and requests per test size the watchdog
  localparam int TEST_WORDS   = 48 + 56 + 9 + 120 + 64;
  localparam int NR_REQS      = 6 + 7 + 4 + 15 + 8;
  localparam int STALL_FACTOR = 8;
  localparam int LIMIT_CYCLES = RESET_CYCLES + 8 + TEST_WORDS * STALL_FACTOR + NR_REQS * 4;

  logic                                 clk_i;
  logic                                 rst_n_i;
  logic                                 req_valid, req_ready;
  logic [vfu_pkg::ID_W-1:0]             req_id;
  vfu_pkg::vfu_op_e                     req_op;
  vfu_pkg::vew_e                        req_sew;
  logic [vfu_pkg::VL_W-1:0]             req_vl;
  logic [vfu_pkg::VREG_IDX_W-1:0]       req_vs1, req_vs2, req_vd;
  logic [31:0]                          req_rs1;
  logic                                 req_use_vs1;
  logic [1:0][7:0]                      vrf_raddr;
  logic [1:0]                           vrf_re, vrf_rvalid;
  logic [1:0][127:0]                    vrf_rdata;
  logic                                 vrf_we;
  logic [7:0]                           vrf_waddr;
  logic [127:0]                         vrf_wdata;
  logic [15:0]                          vrf_wbe;
  logic                                 rsp_valid;
  logic [vfu_pkg::ID_W-1:0]             rsp_id;

  // VRF model and the memory the reference expects
  logic [127:0]                         vrf_mem [NR_ADDR];
  logic [127:0]                         ref_mem [NR_ADDR];

  logic [vfu_pkg::ID_W-1:0]             exp_ids [$];
  int                                   nr_sent;
  int                                   rsp_seen;
  bit                                   req_sent;
  bit                                   stall_mode;

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_inst (.clk_o(clk_i));

  vfu_top vfu_top_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_id_i (req_id),
    .req_op_i (req_op), .req_sew_i (req_sew), .req_vl_i (req_vl),
    .req_vs1_i (req_vs1), .req_vs2_i (req_vs2), .req_vd_i (req_vd),
    .req_rs1_i (req_rs1), .req_use_vs1_i (req_use_vs1),
    .vrf_raddr_o (vrf_raddr), .vrf_re_o (vrf_re),
    .vrf_rdata_i (vrf_rdata), .vrf_rvalid_i (vrf_rvalid),
    .vrf_we_o (vrf_we), .vrf_waddr_o (vrf_waddr), .vrf_wdata_o (vrf_wdata),
    .vrf_wbe_o (vrf_wbe), .rsp_valid_o (rsp_valid), .rsp_id_o (rsp_id)
  );

  ////////////////////
  // Reporting
  ////////////////////

  task automatic fail_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  ////////////////////
  // VRF model
  ////////////////////

  // Read data is only there while the port is enabled
  assign vrf_rdata[0] = vrf_re[0] ? vrf_mem[vrf_raddr[0]] : '0;
  assign vrf_rdata[1] = vrf_re[1] ? vrf_mem[vrf_raddr[1]] : '0;

  always @(negedge clk_i) begin
    vrf_rvalid = stall_mode ? 2'($urandom) : 2'b11;
  end

  // Writes, early output check and response order
  always @(negedge clk_i) begin
    if (vrf_we === 1'b1) begin
      for (int k = 0; k < 16; k++) begin
        if (vrf_wbe[k]) vrf_mem[vrf_waddr][k*8 +: 8] = vrf_wdata[k*8 +: 8];
      end
    end
    if (!req_sent && (vrf_re !== 2'b00 || vrf_we !== 1'b0 || rsp_valid !== 1'b0)) begin
      fail_run("A VRF read, a VRF write or a response appeared before the first request");
    end
    if (rsp_valid === 1'b1) begin
      if (exp_ids.size() == 0) fail_run("A response pulse came with no request outstanding");
      check_value("rsp_id_o", 128'(rsp_id), 128'(exp_ids.pop_front()));
      rsp_seen++;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int vlmax(int sew);
    return int'(vfu_pkg::NR_WORDS_PER_VREG * (vfu_pkg::VRF_BE_W >> sew));
  endfunction

  // Gather element e of nb bytes from a register byte by byte
  function automatic logic [31:0] elem_get(int vreg, int e, int nb);
    logic [31:0] v;
    int          idx;
    v = '0;
    for (int k = 0; k < nb; k++) begin
      idx = e * nb + k;
      v[k*8 +: 8] = ref_mem[vreg * 8 + idx / 16][(idx % 16) * 8 +: 8];
    end
    return v;
  endfunction

  task automatic elem_put(int vreg, int e, int nb, logic [31:0] v);
    int idx;
    for (int k = 0; k < nb; k++) begin
      idx = e * nb + k;
      ref_mem[vreg * 8 + idx / 16][(idx % 16) * 8 +: 8] = v[k*8 +: 8];
    end
  endtask

  task automatic ref_exec(vfu_pkg::vfu_op_e op, int sew, int vl, int vs1, int vs2, int vd,
                          logic [31:0] rs1, bit use_vs1);
    int          nb;
    int          w;
    int          sa;
    int          sb;
    logic [31:0] mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    nb   = 1 << sew;
    w    = 8 * nb;
    mask = (w == 32) ? 32'hffff_ffff : (32'h1 << w) - 32'h1;
    for (int e = 0; e < vl; e++) begin
      a  = elem_get(vs2, e, nb);
      b  = use_vs1 ? elem_get(vs1, e, nb) : (rs1 & mask);
      // Sign-extend both elements for the compare
      sa = int'(a << (32 - w)) >>> (32 - w);
      sb = int'(b << (32 - w)) >>> (32 - w);
      case (op)
        vfu_pkg::VADD: r = a + b;
        vfu_pkg::VSUB: r = a - b;
        vfu_pkg::VAND: r = a & b;
        vfu_pkg::VOR:  r = a | b;
        vfu_pkg::VXOR: r = a ^ b;
        vfu_pkg::VMIN: r = (sa < sb) ? a : b;
        default:       r = (sa < sb) ? b : a;
      endcase
      elem_put(vd, e, nb, r);
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic preset_pattern();
    logic [127:0] word;
    for (int a = 0; a < NR_ADDR; a++) begin
      for (int l = 0; l < 4; l++) begin
        word[l*32 +: 32] = {8'(a), 8'(l), ~8'(a), 8'h5a};
      end
      vrf_mem[a] = word;
      ref_mem[a] = word;
    end
  endtask

  task automatic preset_random();
    logic [127:0] word;
    for (int a = 0; a < NR_ADDR; a++) begin
      for (int l = 0; l < 4; l++) word[l*32 +: 32] = $urandom;
      vrf_mem[a] = word;
      ref_mem[a] = word;
    end
  endtask

  // Called at a falling edge; returns at the falling edge after the accept
  task automatic send_req(vfu_pkg::vfu_op_e op, int sew, int vl, int vs1, int vs2, int vd,
                          logic [31:0] rs1, bit use_vs1);
    logic [vfu_pkg::ID_W-1:0] id;
    id = vfu_pkg::ID_W'(nr_sent);
    ref_exec(op, sew, vl, vs1, vs2, vd, rs1, use_vs1);
    exp_ids.push_back(id);
    nr_sent++;
    req_sent    = 1'b1;
    req_valid   = 1'b1;
    req_id      = id;
    req_op      = op;
    req_sew     = vfu_pkg::vew_e'(sew);
    req_vl      = vfu_pkg::VL_W'(vl);
    req_vs1     = vfu_pkg::VREG_IDX_W'(vs1);
    req_vs2     = vfu_pkg::VREG_IDX_W'(vs2);
    req_vd      = vfu_pkg::VREG_IDX_W'(vd);
    req_rs1     = rs1;
    req_use_vs1 = use_vs1;
    while (req_ready !== 1'b1) @(negedge clk_i);
    @(negedge clk_i);
    req_valid = 1'b0;
  endtask

  task automatic wait_done();
    while (rsp_seen < nr_sent) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic compare_all();
    for (int a = 0; a < NR_ADDR; a++) begin
      check_value($sformatf("vrf word %0d", a), vrf_mem[a], ref_mem[a]);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_idle();
    check_value("req_ready_o", 128'(req_ready), 128'(1));
    repeat (4) @(negedge clk_i);
    check_value("req_ready_o", 128'(req_ready), 128'(1));
  endtask

  task automatic test_vv_add_sub();
    preset_random();
    for (int s = 0; s < 3; s++) begin
      send_req(vfu_pkg::VADD, s, vlmax(s), 2, 1, 16 + 2 * s, '0, 1'b1);
      send_req(vfu_pkg::VSUB, s, vlmax(s), 4, 3, 17 + 2 * s, '0, 1'b1);
    end
    wait_done();
    compare_all();
  endtask

  task automatic test_vx_all_ops();
    preset_random();
    for (int i = 0; i < 7; i++) begin
      send_req(vfu_pkg::vfu_op_e'(i), i % 3, vlmax(i % 3), 0, 3, 16 + i, $urandom, 1'b0);
    end
    wait_done();
    compare_all();
  endtask

  // Tail bytes of vd must keep the address pattern
  task automatic test_tail();
    preset_pattern();
    send_req(vfu_pkg::VADD, 0, 37, 1, 2, 16, '0, 1'b1);
    send_req(vfu_pkg::VXOR, 1, 21, 3, 4, 17, '0, 1'b1);
    send_req(vfu_pkg::VMAX, 2, 7, 5, 6, 18, '0, 1'b1);
    send_req(vfu_pkg::VSUB, 2, 3, 0, 7, 19, $urandom, 1'b0);
    wait_done();
    compare_all();
  endtask

  task automatic test_random_ops();
    vfu_pkg::vfu_op_e ops [5];
    ops = '{vfu_pkg::VMIN, vfu_pkg::VMAX, vfu_pkg::VAND, vfu_pkg::VOR, vfu_pkg::VXOR};
    preset_random();
    for (int s = 0; s < 3; s++) begin
      for (int k = 0; k < 5; k++) begin
        send_req(ops[k], s, vlmax(s), 1 + k, 6 + k, 16 + s * 5 + k, '0, 1'b1);
      end
    end
    wait_done();
    compare_all();
  endtask

  task automatic test_stall();
    int sew;
    preset_random();
    stall_mode = 1'b1;
    for (int i = 0; i < 8; i++) begin
      sew = int'($urandom_range(2, 0));
      send_req(vfu_pkg::vfu_op_e'($urandom_range(6, 0)), sew,
               int'($urandom_range(vlmax(sew), 1)), int'($urandom_range(15, 0)),
               int'($urandom_range(15, 0)), 16 + i, $urandom, 1'($urandom_range(1, 0)));
    end
    wait_done();
    stall_mode = 1'b0;
    compare_all();
  endtask

  ////////////////////
  // Main sequence and watchdog
  ////////////////////

  initial begin
    void'($urandom(32'hbad9_4f71));
    rst_n_i     = 1'b0;
    req_valid   = 1'b0;
    req_id      = '0;
    req_op      = vfu_pkg::VADD;
    req_sew     = vfu_pkg::EW_8;
    req_vl      = '0;
    req_vs1     = '0;
    req_vs2     = '0;
    req_vd      = '0;
    req_rs1     = '0;
    req_use_vs1 = 1'b0;
    vrf_rvalid  = 2'b11;
    stall_mode  = 1'b0;
    nr_sent     = 0;
    rsp_seen    = 0;
    req_sent    = 1'b0;
    preset_pattern();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_idle();
    test_vv_add_sub();
    test_vx_all_ops();
    test_tail();
    test_random_ops();
    test_stall();
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    fail_run("Watchdog timeout, the tests did not finish in time");
  end

endmodule

/* sim/tb_clock.sv */
////////////////////
// Free-running testbench clock, low for the first half period
////////////////////

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

/* src/vfu_top.sv */
////////////////////
// Integer vector functional unit, top level
// Words are written two cycles after issue; several may be in flight
////////////////////

module vfu_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Request
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  logic [vfu_pkg::ID_W-1:0]                    req_id_i,
  input  vfu_pkg::vfu_op_e                            req_op_i,
  input  vfu_pkg::vew_e                               req_sew_i,
  input  logic [vfu_pkg::VL_W-1:0]                    req_vl_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vs1_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vs2_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vd_i,
  input  logic [vfu_pkg::ELEN-1:0]                    req_rs1_i,
  input  logic                                        req_use_vs1_i,
  // VRF read
  output logic [1:0][vfu_pkg::VREG_ADDR_W-1:0]        vrf_raddr_o,
  output logic [1:0]                                  vrf_re_o,
  input  logic [1:0][vfu_pkg::VRF_DATA_W-1:0]         vrf_rdata_i,
  input  logic [1:0]                                  vrf_rvalid_i,
  // VRF write
  output logic                                        vrf_we_o,
  output logic [vfu_pkg::VREG_ADDR_W-1:0]             vrf_waddr_o,
  output logic [vfu_pkg::VRF_DATA_W-1:0]              vrf_wdata_o,
  output logic [vfu_pkg::VRF_BE_W-1:0]                vrf_wbe_o,
  // Response
  output logic                                        rsp_valid_o,
  output logic [vfu_pkg::ID_W-1:0]                    rsp_id_o
);

  // Decode to execute
  logic                              issue_valid;
  vfu_pkg::vfu_op_e                  issue_op;
  vfu_pkg::vew_e                     issue_sew;
  logic [vfu_pkg::VRF_DATA_W-1:0]    issue_opa, issue_opb;
  logic [vfu_pkg::VREG_ADDR_W-1:0]   issue_waddr;
  logic [vfu_pkg::NR_ELEM_W-1:0]     issue_nr_elem;
  logic                              issue_last;
  logic [vfu_pkg::ID_W-1:0]          issue_id;

  // Execute to result
  logic                              ex_valid;
  logic [vfu_pkg::VRF_DATA_W-1:0]    ex_data;
  vfu_pkg::vew_e                     ex_sew;
  logic [vfu_pkg::VREG_ADDR_W-1:0]   ex_waddr;
  logic [vfu_pkg::NR_ELEM_W-1:0]     ex_nr_elem;
  logic                              ex_last;
  logic [vfu_pkg::ID_W-1:0]          ex_id;

  vfu_decode decode_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .req_valid_i (req_valid_i), .req_ready_o (req_ready_o),
    .req_id_i (req_id_i), .req_op_i (req_op_i), .req_sew_i (req_sew_i),
    .req_vl_i (req_vl_i), .req_vs1_i (req_vs1_i), .req_vs2_i (req_vs2_i),
    .req_vd_i (req_vd_i), .req_rs1_i (req_rs1_i), .req_use_vs1_i (req_use_vs1_i),
    .vrf_raddr_o (vrf_raddr_o), .vrf_re_o (vrf_re_o),
    .vrf_rdata_i (vrf_rdata_i), .vrf_rvalid_i (vrf_rvalid_i),
    .issue_valid_o (issue_valid), .issue_op_o (issue_op), .issue_sew_o (issue_sew),
    .issue_opa_o (issue_opa), .issue_opb_o (issue_opb), .issue_waddr_o (issue_waddr),
    .issue_nr_elem_o (issue_nr_elem), .issue_last_o (issue_last), .issue_id_o (issue_id)
  );

  vfu_execute execute_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .issue_valid_i (issue_valid), .issue_op_i (issue_op), .issue_sew_i (issue_sew),
    .issue_opa_i (issue_opa), .issue_opb_i (issue_opb), .issue_waddr_i (issue_waddr),
    .issue_nr_elem_i (issue_nr_elem), .issue_last_i (issue_last), .issue_id_i (issue_id),
    .ex_valid_o (ex_valid), .ex_data_o (ex_data), .ex_sew_o (ex_sew),
    .ex_waddr_o (ex_waddr), .ex_nr_elem_o (ex_nr_elem), .ex_last_o (ex_last),
    .ex_id_o (ex_id)
  );

  vfu_result result_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .ex_valid_i (ex_valid), .ex_data_i (ex_data), .ex_sew_i (ex_sew),
    .ex_waddr_i (ex_waddr), .ex_nr_elem_i (ex_nr_elem), .ex_last_i (ex_last),
    .ex_id_i (ex_id),
    .vrf_we_o (vrf_we_o), .vrf_waddr_o (vrf_waddr_o), .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o (vrf_wbe_o), .rsp_valid_o (rsp_valid_o), .rsp_id_o (rsp_id_o)
  );

endmodule

/* src/vfu_result.sv */
////////////////////
// VRF write stage and response pulse
// The byte enable is low-aligned; bytes past vl are left untouched
// The VRF always takes the write, so there is no back-pressure
////////////////////

module vfu_result (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 ex_valid_i,
  input  logic [vfu_pkg::VRF_DATA_W-1:0]       ex_data_i,
  input  vfu_pkg::vew_e                        ex_sew_i,
  input  logic [vfu_pkg::VREG_ADDR_W-1:0]      ex_waddr_i,
  input  logic [vfu_pkg::NR_ELEM_W-1:0]        ex_nr_elem_i,
  input  logic                                 ex_last_i,
  input  logic [vfu_pkg::ID_W-1:0]             ex_id_i,
  output logic                                 vrf_we_o,
  output logic [vfu_pkg::VREG_ADDR_W-1:0]      vrf_waddr_o,
  output logic [vfu_pkg::VRF_DATA_W-1:0]       vrf_wdata_o,
  output logic [vfu_pkg::VRF_BE_W-1:0]         vrf_wbe_o,
  output logic                                 rsp_valid_o,
  output logic [vfu_pkg::ID_W-1:0]             rsp_id_o
);

  logic [vfu_pkg::NR_ELEM_W-1:0] nr_bytes;
  logic [vfu_pkg::VRF_BE_W-1:0]  be;

  // Element count scaled to bytes, at most a full word
  assign nr_bytes = vfu_pkg::NR_ELEM_W'(ex_nr_elem_i << ex_sew_i);

  // A shift by the full width leaves all bytes enabled
  assign be = ~({vfu_pkg::VRF_BE_W{1'b1}} << nr_bytes);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_we_o    <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      vrf_we_o    <= ex_valid_i;
      // Same cycle as the write of the last word
      rsp_valid_o <= ex_valid_i && ex_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_valid_i) begin
      vrf_waddr_o <= ex_waddr_i;
      vrf_wdata_o <= ex_data_i;
      vrf_wbe_o   <= be;
      rsp_id_o    <= ex_id_i;
    end
  end

  // Decode never issues an empty word
  a_wbe_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o |-> vrf_wbe_o != '0);

endmodule

/* src/vfu_execute.sv */
////////////////////
// Lane ALUs and the single execute pipeline stage
// Accepts one word per cycle; the tag moves with the data
////////////////////

module vfu_execute (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 issue_valid_i,
  input  vfu_pkg::vfu_op_e                     issue_op_i,
  input  vfu_pkg::vew_e                        issue_sew_i,
  input  logic [vfu_pkg::VRF_DATA_W-1:0]       issue_opa_i,
  input  logic [vfu_pkg::VRF_DATA_W-1:0]       issue_opb_i,
  input  logic [vfu_pkg::VREG_ADDR_W-1:0]      issue_waddr_i,
  input  logic [vfu_pkg::NR_ELEM_W-1:0]        issue_nr_elem_i,
  input  logic                                 issue_last_i,
  input  logic [vfu_pkg::ID_W-1:0]             issue_id_i,
  output logic                                 ex_valid_o,
  output logic [vfu_pkg::VRF_DATA_W-1:0]       ex_data_o,
  output vfu_pkg::vew_e                        ex_sew_o,
  output logic [vfu_pkg::VREG_ADDR_W-1:0]      ex_waddr_o,
  output logic [vfu_pkg::NR_ELEM_W-1:0]        ex_nr_elem_o,
  output logic                                 ex_last_o,
  output logic [vfu_pkg::ID_W-1:0]             ex_id_o
);

  logic [vfu_pkg::VRF_DATA_W-1:0] lane_res;

  for (genvar l = 0; l < vfu_pkg::N_LANE; l++) begin : gen_lanes
    vfu_lane_alu lane_alu_inst (
      .op_i     (issue_op_i),
      .sew_i    (issue_sew_i),
      .opa_i    (issue_opa_i[l*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .opb_i    (issue_opb_i[l*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .result_o (lane_res[l*vfu_pkg::ELEN +: vfu_pkg::ELEN])
    );
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= issue_valid_i;
    end
  end

  // Data and tag, loaded only for a real word
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      ex_data_o    <= lane_res;
      ex_sew_o     <= issue_sew_i;
      ex_waddr_o   <= issue_waddr_i;
      ex_nr_elem_o <= issue_nr_elem_i;
      ex_last_o    <= issue_last_i;
      ex_id_o      <= issue_id_i;
    end
  end

  a_sew_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i |-> issue_sew_i inside {vfu_pkg::EW_8, vfu_pkg::EW_16, vfu_pkg::EW_32});

endmodule

/* src/vfu_decode.sv */
////////////////////
// Request holding register and word sequencer
// Holds one instruction; accepts the next only after the last word issues
// Expects 1 <= vl <= VLMAX; no hazard check between instructions
////////////////////

module vfu_decode (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Request
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  logic [vfu_pkg::ID_W-1:0]                    req_id_i,
  input  vfu_pkg::vfu_op_e                            req_op_i,
  input  vfu_pkg::vew_e                               req_sew_i,
  input  logic [vfu_pkg::VL_W-1:0]                    req_vl_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vs1_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vs2_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0]              req_vd_i,
  input  logic [vfu_pkg::ELEN-1:0]                    req_rs1_i,
  input  logic                                        req_use_vs1_i,
  // VRF read ports, 0 is vs2 and 1 is vs1
  output logic [1:0][vfu_pkg::VREG_ADDR_W-1:0]        vrf_raddr_o,
  output logic [1:0]                                  vrf_re_o,
  input  logic [1:0][vfu_pkg::VRF_DATA_W-1:0]         vrf_rdata_i,
  input  logic [1:0]                                  vrf_rvalid_i,
  // Issue to execute
  output logic                                        issue_valid_o,
  output vfu_pkg::vfu_op_e                            issue_op_o,
  output vfu_pkg::vew_e                               issue_sew_o,
  output logic [vfu_pkg::VRF_DATA_W-1:0]              issue_opa_o,
  output logic [vfu_pkg::VRF_DATA_W-1:0]              issue_opb_o,
  output logic [vfu_pkg::VREG_ADDR_W-1:0]             issue_waddr_o,
  output logic [vfu_pkg::NR_ELEM_W-1:0]               issue_nr_elem_o,
  output logic                                        issue_last_o,
  output logic [vfu_pkg::ID_W-1:0]                    issue_id_o
);

  // Register index times words per register plus word offset
  function automatic logic [vfu_pkg::VREG_ADDR_W-1:0] word_addr(
    logic [vfu_pkg::VREG_IDX_W-1:0] vreg,
    logic [vfu_pkg::WORD_CNT_W-1:0] word
  );
    return vfu_pkg::VREG_ADDR_W'(vreg) * vfu_pkg::VREG_ADDR_W'(vfu_pkg::NR_WORDS_PER_VREG)
           + vfu_pkg::VREG_ADDR_W'(word);
  endfunction

  logic                              held_q;
  logic [vfu_pkg::WORD_CNT_W-1:0]    word_q;
  logic [vfu_pkg::VL_W-1:0]          rem_q;

  // Held payload
  vfu_pkg::vfu_op_e                  op_q;
  vfu_pkg::vew_e                     sew_q;
  logic [vfu_pkg::ID_W-1:0]          id_q;
  logic [vfu_pkg::VREG_IDX_W-1:0]    vs1_q, vs2_q, vd_q;
  logic [vfu_pkg::ELEN-1:0]          rs1_q;
  logic                              use_vs1_q;

  logic                              accept;
  logic                              issue;
  logic                              last_word;
  logic [vfu_pkg::NR_ELEM_W-1:0]     elem_per_word;
  vfu_pkg::lane_word_u               rs1_rep;

  assign req_ready_o = !held_q;
  assign accept      = req_valid_i && req_ready_o;

  // 16, 8 or 4 elements per word
  assign elem_per_word = vfu_pkg::NR_ELEM_W'(vfu_pkg::VRF_BE_W >> sew_q);
  assign last_word     = rem_q <= vfu_pkg::VL_W'(elem_per_word);

  // vs1 only matters for the vector-vector form
  assign issue = held_q && vrf_rvalid_i[0] && (!use_vs1_q || vrf_rvalid_i[1]);

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q <= 1'b0;
      word_q <= '0;
      rem_q  <= '0;
    end else if (accept) begin
      held_q <= 1'b1;
      word_q <= '0;
      rem_q  <= req_vl_i;
    end else if (issue) begin
      // Release on the last word
      held_q <= !last_word;
      word_q <= word_q + 1'b1;
      rem_q  <= rem_q - vfu_pkg::VL_W'(elem_per_word);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= req_op_i;
      sew_q     <= req_sew_i;
      id_q      <= req_id_i;
      vs1_q     <= req_vs1_i;
      vs2_q     <= req_vs2_i;
      vd_q      <= req_vd_i;
      rs1_q     <= req_rs1_i;
      use_vs1_q <= req_use_vs1_i;
    end
  end

  ////////////////////
  // Operands
  ////////////////////

  assign vrf_re_o       = {held_q && use_vs1_q, held_q};
  assign vrf_raddr_o[0] = word_addr(vs2_q, word_q);
  assign vrf_raddr_o[1] = word_addr(vs1_q, word_q);

  // Scalar replicated at the element width
  always_comb begin
    unique case (sew_q)
      vfu_pkg::EW_8:  rs1_rep.b = {4{rs1_q[7:0]}};
      vfu_pkg::EW_16: rs1_rep.h = {2{rs1_q[15:0]}};
      default:        rs1_rep.w = rs1_q;
    endcase
  end

  assign issue_valid_o   = issue;
  assign issue_op_o      = op_q;
  assign issue_sew_o     = sew_q;
  assign issue_opa_o     = vrf_rdata_i[0];
  assign issue_opb_o     = use_vs1_q ? vrf_rdata_i[1] : {vfu_pkg::N_LANE{rs1_rep.w}};
  assign issue_waddr_o   = word_addr(vd_q, word_q);
  assign issue_nr_elem_o = last_word ? vfu_pkg::NR_ELEM_W'(rem_q) : elem_per_word;
  assign issue_last_o    = last_word;
  assign issue_id_o      = id_q;

  // vl must fit the destination register at the requested width
  a_vl_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (req_vl_i != '0) &&
      (int'(req_vl_i) <= vfu_pkg::NR_WORDS_PER_VREG * (vfu_pkg::VRF_BE_W >> req_sew_i)));

endmodule

/* src/vfu_lane_alu.sv */
////////////////////
// Combinational SIMD integer ALU for one 32-bit lane
// Add and sub wrap per element; min and max compare signed
////////////////////

module vfu_lane_alu (
  input  vfu_pkg::vfu_op_e            op_i,
  input  vfu_pkg::vew_e               sew_i,
  input  logic [vfu_pkg::ELEN-1:0]    opa_i,
  input  logic [vfu_pkg::ELEN-1:0]    opb_i,
  output logic [vfu_pkg::ELEN-1:0]    result_o
);

  // Operands arrive sign-extended, so the low bits of the result
  // are correct for any narrower element
  function automatic logic [vfu_pkg::ELEN-1:0] elem_op(
    vfu_pkg::vfu_op_e                op,
    logic signed [vfu_pkg::ELEN-1:0] a,
    logic signed [vfu_pkg::ELEN-1:0] b
  );
    case (op)
      vfu_pkg::VSUB: return a - b;
      vfu_pkg::VAND: return a & b;
      vfu_pkg::VOR:  return a | b;
      vfu_pkg::VXOR: return a ^ b;
      vfu_pkg::VMIN: return (a < b) ? a : b;
      vfu_pkg::VMAX: return (a < b) ? b : a;
      default:       return a + b;
    endcase
  endfunction

  vfu_pkg::lane_word_u a, b;
  vfu_pkg::lane_word_u r8, r16, r32;

  assign a.w = opa_i;
  assign b.w = opb_i;

  always_comb begin
    for (int i = 0; i < vfu_pkg::ELENB; i++) begin
      r8.b[i] = 8'(elem_op(op_i, vfu_pkg::ELEN'(signed'(a.b[i])),
                           vfu_pkg::ELEN'(signed'(b.b[i]))));
    end
    for (int i = 0; i < vfu_pkg::ELENB / 2; i++) begin
      r16.h[i] = 16'(elem_op(op_i, vfu_pkg::ELEN'(signed'(a.h[i])),
                             vfu_pkg::ELEN'(signed'(b.h[i]))));
    end
    r32.w = elem_op(op_i, a.w, b.w);
  end

  // Pick the view that matches the element width
  always_comb begin
    unique case (sew_i)
      vfu_pkg::EW_8:  result_o = r8.w;
      vfu_pkg::EW_16: result_o = r16.w;
      default:        result_o = r32.w;
    endcase
  end

endmodule

/* src/vfu_pkg.sv */
////////////////////
// Shared sizes and types for the integer vector functional unit
// The VRF word is N_LANE lanes of ELEN bits with one byte enable per byte
// Vector registers are NR_WORDS_PER_VREG consecutive VRF words
////////////////////

package vfu_pkg;

  ////////////////////
  // Datapath sizes
  ////////////////////

  localparam int unsigned N_LANE = 4;
  localparam int unsigned ELEN   = 32;
  localparam int unsigned ELENB  = ELEN / 8;

  localparam int unsigned VRF_DATA_W = N_LANE * ELEN;
  localparam int unsigned VRF_BE_W   = N_LANE * ELENB;

  ////////////////////
  // Register file layout
  ////////////////////

  localparam int unsigned NR_VREG           = 32;
  localparam int unsigned NR_WORDS_PER_VREG = 8;
  localparam int unsigned VREG_IDX_W        = $clog2(NR_VREG);
  localparam int unsigned WORD_CNT_W        = $clog2(NR_WORDS_PER_VREG);
  localparam int unsigned VREG_ADDR_W       = 8;

  // Vector length in elements, up to 128 bytes at 8-bit elements
  localparam int unsigned VL_W = 8;

  // Valid elements in one word, 0 to 16
  localparam int unsigned NR_ELEM_W = $clog2(VRF_BE_W) + 1;

  localparam int unsigned ID_W = 2;

  ////////////////////
  // Encodings
  ////////////////////

  // Element width, also the log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VMIN = 3'd5,
    VMAX = 3'd6
  } vfu_op_e;

  // One lane word seen as bytes, halfwords or a full word
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
    logic [31:0]      w;
  } lane_word_u;

endpackage
